// ==== rtl/chiplet_types_pkg.sv ====
package chiplet_types_pkg;

    // Flit word width and virtual channels per port
    localparam int FLIT_W = 32;
    localparam int NUM_VCS = 2;

    typedef logic [4:0] node_id_t;

    // Wide enough for the default four ports
    typedef logic [1:0] port_id_t;

    typedef enum logic [3:0] {
        FMT_DATA       = 4'h0,
        FMT_SWITCH_CFG = 4'h1
    } fmt_t;

    // Ordinary payload flit
    typedef struct packed {
        fmt_t             format;
        node_id_t         dest;
        logic [22:0]      payload;
    } data_word_t;

    // Route table write; table_index names the node whose route changes
    typedef struct packed {
        fmt_t             format;
        node_id_t         dest;
        node_id_t         table_index;
        port_id_t         route_port;
        logic [15:0]      spare;
    } cfg_word_t;

    // Format and destination line up in both views
    typedef union packed {
        data_word_t       data;
        cfg_word_t        cfg;
    } flit_payload_t;

endpackage

// ==== rtl/vc_input_buffers.sv ====
`timescale 1ns/10ps

module vc_input_buffers import chiplet_types_pkg::*; #(
    parameter int NUM_PORTS = 4,
    parameter int BUFFER_SIZE = 4
) (
    input  logic                                clk,
    input  logic                                rst_n,
    input  flit_payload_t [NUM_PORTS-1:0]       in_flit,
    input  logic [NUM_PORTS-1:0]                in_vc,
    input  logic [NUM_PORTS-1:0]                data_ready_in,
    input  logic [NUM_VCS*NUM_PORTS-1:0]        pop,
    output flit_payload_t [NUM_VCS*NUM_PORTS-1:0] head_flit,
    output logic [NUM_VCS*NUM_PORTS-1:0]        head_valid,
    output logic [NUM_PORTS-1:0][NUM_VCS-1:0]   buffer_available
);
    localparam int NUM_BUF = NUM_VCS * NUM_PORTS;
    localparam int PTR_W = (BUFFER_SIZE > 1) ? $clog2(BUFFER_SIZE) : 1;
    localparam int CNT_W = $clog2(BUFFER_SIZE + 1);

    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(BUFFER_SIZE - 1)) ? '0 : ptr + 1'b1;
    endfunction

    // Buffer index is vc * NUM_PORTS + port
    for (genvar b = 0; b < NUM_BUF; b++) begin : g_buf
        localparam int PORT = b % NUM_PORTS;
        localparam int VC = b / NUM_PORTS;

        logic [FLIT_W-1:0] mem [BUFFER_SIZE];
        logic [PTR_W-1:0]  rd_ptr;
        logic [PTR_W-1:0]  wr_ptr;
        logic [CNT_W-1:0]  count;
        logic              wen;

        // Steer the port's write by its VC bit
        assign wen = data_ready_in[PORT] && (in_vc[PORT] == 1'(VC));

        always_ff @(posedge clk or negedge rst_n) begin
            if (!rst_n) begin
                rd_ptr <= '0;
                wr_ptr <= '0;
                count <= '0;
            end else begin
                if (wen) begin
                    wr_ptr <= ptr_inc(wr_ptr);
                end
                if (pop[b]) begin
                    rd_ptr <= ptr_inc(rd_ptr);
                end
                case ({wen, pop[b]})
                    2'b10:   count <= count + 1'b1;
                    2'b01:   count <= count - 1'b1;
                    default: count <= count;
                endcase
            end
        end

        always_ff @(posedge clk) begin
            if (wen) begin
                mem[wr_ptr] <= in_flit[PORT];
            end
        end

        assign head_flit[b] = mem[rd_ptr];
        assign head_valid[b] = (count != '0);
        // Level seen by the sender, one cycle behind the write
        assign buffer_available[PORT][VC] = (count < CNT_W'(BUFFER_SIZE));

        a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
            wen |-> count != CNT_W'(BUFFER_SIZE));
        a_no_underflow: assert property (@(posedge clk) disable iff (!rst_n)
            pop[b] |-> count != '0);
    end

endmodule

// ==== rtl/route_compute.sv ====
`timescale 1ns/10ps

module route_compute import chiplet_types_pkg::*; #(
    parameter int NUM_PORTS = 4,
    parameter int TOTAL_NODES = 32,
    parameter node_id_t NODE = 5'd3
) (
    input  flit_payload_t [NUM_VCS*NUM_PORTS-1:0] head_flit,
    input  logic [NUM_VCS*NUM_PORTS-1:0]          head_valid,
    input  port_id_t [TOTAL_NODES-1:0]            route_table,
    output port_id_t [NUM_VCS*NUM_PORTS-1:0]      req_port,
    output logic [NUM_VCS*NUM_PORTS-1:0]          req_valid
);
    localparam int NUM_BUF = NUM_VCS * NUM_PORTS;

    // Config flits route by destination like data, so the data view is enough
    always_comb begin
        node_id_t dest;
        for (int b = 0; b < NUM_BUF; b++) begin
            dest = head_flit[b].data.dest;
            if (dest == NODE) begin
                req_port[b] = '0;
            end else if (int'(dest) < TOTAL_NODES) begin
                req_port[b] = route_table[dest];
            end else begin
                // Nodes outside the table eject locally
                req_port[b] = '0;
            end
        end
    end

    // Every buffered head requests its output
    assign req_valid = head_valid;

endmodule

// ==== rtl/switch_reg_bank.sv ====
`timescale 1ns/10ps

module switch_reg_bank import chiplet_types_pkg::*; #(
    parameter int NUM_PORTS = 4,
    parameter int TOTAL_NODES = 32,
    parameter node_id_t NODE = 5'd3
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        claim_valid,
    input  flit_payload_t               claim_flit,
    output port_id_t [TOTAL_NODES-1:0]  route_table
);
    cfg_word_t cfg;

    // Claimed flits are always read as configuration words
    assign cfg = claim_flit.cfg;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            // Default spread is node mod ports, local node ejects
            for (int n = 0; n < TOTAL_NODES; n++) begin
                if (n == int'(NODE)) begin
                    route_table[n] <= '0;
                end else begin
                    route_table[n] <= port_id_t'(n % NUM_PORTS);
                end
            end
        end else if (claim_valid && int'(cfg.table_index) < TOTAL_NODES) begin
            route_table[cfg.table_index] <= cfg.route_port;
        end
    end

    a_index_range: assert property (@(posedge clk) disable iff (!rst_n)
        claim_valid |-> int'(cfg.table_index) < TOTAL_NODES);

endmodule

// ==== rtl/switch_allocator.sv ====
`timescale 1ns/10ps

module switch_allocator import chiplet_types_pkg::*; #(
    parameter int NUM_PORTS = 4,
    parameter int BUFFER_SIZE = 4
) (
    input  logic                                      clk,
    input  logic                                      rst_n,
    input  port_id_t [NUM_VCS*NUM_PORTS-1:0]          req_port,
    input  logic [NUM_VCS*NUM_PORTS-1:0]              req_valid,
    input  logic [NUM_VCS*NUM_PORTS-1:0]              head_vc,
    input  logic [NUM_PORTS-1:0][NUM_VCS-1:0]         credit_granted,
    output logic [NUM_PORTS-1:0][NUM_VCS*NUM_PORTS-1:0] grant,
    output logic [NUM_PORTS-1:0]                      grant_valid,
    output logic [NUM_VCS*NUM_PORTS-1:0]              pop
);
    localparam int NUM_BUF = NUM_VCS * NUM_PORTS;
    localparam int BUF_W = $clog2(NUM_BUF);
    localparam int CNT_W = $clog2(BUFFER_SIZE + 1);

    logic [NUM_PORTS-1:0][BUF_W-1:0]              rr_ptr;
    logic [NUM_PORTS-1:0][BUF_W-1:0]              winner;
    logic [NUM_PORTS-1:0][NUM_VCS-1:0][CNT_W-1:0] credits;

    // Search from each pointer for the first requester with credit
    always_comb begin
        int idx;
        grant = '0;
        grant_valid = '0;
        winner = '0;
        for (int o = 0; o < NUM_PORTS; o++) begin
            for (int i = 0; i < NUM_BUF; i++) begin
                idx = (int'(rr_ptr[o]) + i) % NUM_BUF;
                if (!grant_valid[o] && req_valid[idx] && req_port[idx] == port_id_t'(o)
                        && credits[o][head_vc[idx]] != '0) begin
                    grant_valid[o] = 1'b1;
                    grant[o][idx] = 1'b1;
                    winner[o] = BUF_W'(idx);
                end
            end
        end
    end

    // A buffer asks for one output only, so at most one grant per buffer
    always_comb begin
        pop = '0;
        for (int o = 0; o < NUM_PORTS; o++) begin
            pop |= grant[o];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        logic take;
        if (!rst_n) begin
            rr_ptr <= '0;
            for (int o = 0; o < NUM_PORTS; o++) begin
                for (int v = 0; v < NUM_VCS; v++) begin
                    credits[o][v] <= CNT_W'(BUFFER_SIZE);
                end
            end
        end else begin
            for (int o = 0; o < NUM_PORTS; o++) begin
                // Winner gets lowest priority next time
                if (grant_valid[o]) begin
                    rr_ptr[o] <= (winner[o] == BUF_W'(NUM_BUF - 1)) ? '0 : winner[o] + 1'b1;
                end
                for (int v = 0; v < NUM_VCS; v++) begin
                    take = grant_valid[o] && (head_vc[winner[o]] == 1'(v));
                    case ({take, credit_granted[o][v]})
                        2'b10:   credits[o][v] <= credits[o][v] - 1'b1;
                        2'b01:   credits[o][v] <= credits[o][v] + 1'b1;
                        default: credits[o][v] <= credits[o][v];
                    endcase
                end
            end
        end
    end

    for (genvar o = 0; o < NUM_PORTS; o++) begin : g_chk
        a_grant_onehot: assert property (@(posedge clk) disable iff (!rst_n)
            grant_valid[o] |-> $onehot(grant[o]));
        for (genvar v = 0; v < NUM_VCS; v++) begin : g_vc
            // Downstream must not return more than it was given
            a_credit_max: assert property (@(posedge clk) disable iff (!rst_n)
                credits[o][v] <= CNT_W'(BUFFER_SIZE));
        end
    end

endmodule

// ==== rtl/crossbar.sv ====
`timescale 1ns/10ps

module crossbar import chiplet_types_pkg::*; #(
    parameter int NUM_PORTS = 4,
    parameter node_id_t NODE = 5'd3
) (
    input  logic                                      clk,
    input  logic                                      rst_n,
    input  flit_payload_t [NUM_VCS*NUM_PORTS-1:0]     head_flit,
    input  logic [NUM_VCS*NUM_PORTS-1:0]              head_vc,
    input  logic [NUM_PORTS-1:0][NUM_VCS*NUM_PORTS-1:0] grant,
    input  logic [NUM_PORTS-1:0]                      grant_valid,
    output flit_payload_t [NUM_PORTS-1:0]             out_flit,
    output logic [NUM_PORTS-1:0]                      out_vc,
    output logic [NUM_PORTS-1:0]                      data_ready_out,
    output logic                                      claim_valid,
    output flit_payload_t                             claim_flit
);
    localparam int NUM_BUF = NUM_VCS * NUM_PORTS;

    flit_payload_t [NUM_PORTS-1:0] mux_flit;
    logic [NUM_PORTS-1:0]          mux_vc;
    logic [NUM_PORTS-1:0]          out_valid;

    // Grants are one-hot per output
    always_comb begin
        mux_flit = '0;
        mux_vc = '0;
        for (int o = 0; o < NUM_PORTS; o++) begin
            for (int b = 0; b < NUM_BUF; b++) begin
                if (grant[o][b]) begin
                    mux_flit[o] = head_flit[b];
                    mux_vc[o] = head_vc[b];
                end
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= '0;
        end else begin
            out_valid <= grant_valid;
        end
    end

    always_ff @(posedge clk) begin
        out_flit <= mux_flit;
        out_vc <= mux_vc;
    end

    // Config flit for this node on the local port goes to the route table
    assign claim_valid = out_valid[0] && out_flit[0].data.format == FMT_SWITCH_CFG
                         && out_flit[0].data.dest == NODE;
    assign claim_flit = out_flit[0];

    always_comb begin
        data_ready_out = out_valid;
        data_ready_out[0] = out_valid[0] && !claim_valid;
    end

endmodule

// ==== rtl/switch.sv ====
`timescale 1ns/10ps

module switch import chiplet_types_pkg::*; #(
    parameter int NUM_PORTS = 4,
    parameter int BUFFER_SIZE = 4,
    parameter int TOTAL_NODES = 32,
    parameter node_id_t NODE = 5'd3
) (
    input  logic                                clk,
    input  logic                                rst_n,
    input  flit_payload_t [NUM_PORTS-1:0]       in_flit,
    input  logic [NUM_PORTS-1:0]                in_vc,
    input  logic [NUM_PORTS-1:0]                data_ready_in,
    output logic [NUM_PORTS-1:0][NUM_VCS-1:0]   buffer_available,
    output flit_payload_t [NUM_PORTS-1:0]       out_flit,
    output logic [NUM_PORTS-1:0]                out_vc,
    output logic [NUM_PORTS-1:0]                data_ready_out,
    input  logic [NUM_PORTS-1:0][NUM_VCS-1:0]   credit_granted
);
    localparam int NUM_BUF = NUM_VCS * NUM_PORTS;

    flit_payload_t [NUM_BUF-1:0]          head_flit;
    logic [NUM_BUF-1:0]                   head_valid;
    logic [NUM_BUF-1:0]                   head_vc;
    logic [NUM_BUF-1:0]                   pop;
    port_id_t [NUM_BUF-1:0]               req_port;
    logic [NUM_BUF-1:0]                   req_valid;
    port_id_t [TOTAL_NODES-1:0]           route_table;
    logic [NUM_PORTS-1:0][NUM_BUF-1:0]    grant;
    logic [NUM_PORTS-1:0]                 grant_valid;
    logic                                 claim_valid;
    flit_payload_t                        claim_flit;
    logic [NUM_PORTS-1:0][NUM_VCS-1:0]    credit_in;

    // Upper half of the buffers holds VC 1
    for (genvar b = 0; b < NUM_BUF; b++) begin : g_head_vc
        assign head_vc[b] = (b >= NUM_PORTS);
    end

    // A claimed flit never leaves, so hand its credit straight back
    always_comb begin
        credit_in = credit_granted;
        for (int v = 0; v < NUM_VCS; v++) begin
            credit_in[0][v] = credit_granted[0][v] | (claim_valid && out_vc[0] == 1'(v));
        end
    end

    vc_input_buffers #(
        .NUM_PORTS(NUM_PORTS),
        .BUFFER_SIZE(BUFFER_SIZE)
    ) u_buffers (
        .clk(clk),
        .rst_n(rst_n),
        .in_flit(in_flit),
        .in_vc(in_vc),
        .data_ready_in(data_ready_in),
        .pop(pop),
        .head_flit(head_flit),
        .head_valid(head_valid),
        .buffer_available(buffer_available)
    );

    route_compute #(
        .NUM_PORTS(NUM_PORTS),
        .TOTAL_NODES(TOTAL_NODES),
        .NODE(NODE)
    ) u_route (
        .head_flit(head_flit),
        .head_valid(head_valid),
        .route_table(route_table),
        .req_port(req_port),
        .req_valid(req_valid)
    );

    switch_reg_bank #(
        .NUM_PORTS(NUM_PORTS),
        .TOTAL_NODES(TOTAL_NODES),
        .NODE(NODE)
    ) u_reg_bank (
        .clk(clk),
        .rst_n(rst_n),
        .claim_valid(claim_valid),
        .claim_flit(claim_flit),
        .route_table(route_table)
    );

    switch_allocator #(
        .NUM_PORTS(NUM_PORTS),
        .BUFFER_SIZE(BUFFER_SIZE)
    ) u_alloc (
        .clk(clk),
        .rst_n(rst_n),
        .req_port(req_port),
        .req_valid(req_valid),
        .head_vc(head_vc),
        .credit_granted(credit_in),
        .grant(grant),
        .grant_valid(grant_valid),
        .pop(pop)
    );

    crossbar #(
        .NUM_PORTS(NUM_PORTS),
        .NODE(NODE)
    ) u_crossbar (
        .clk(clk),
        .rst_n(rst_n),
        .head_flit(head_flit),
        .head_vc(head_vc),
        .grant(grant),
        .grant_valid(grant_valid),
        .out_flit(out_flit),
        .out_vc(out_vc),
        .data_ready_out(data_ready_out),
        .claim_valid(claim_valid),
        .claim_flit(claim_flit)
    );

endmodule

// ==== test/switch_checker.sv ====
`timescale 1ns/10ps

module switch_checker import chiplet_types_pkg::*; #(
    parameter int NUM_PORTS = 4,
    parameter int BUFFER_SIZE = 4,
    parameter int TOTAL_NODES = 32,
    parameter node_id_t NODE = 5'd3
) (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  logic [8*12-1:0]                      test_name,
    input  logic                                 hold,
    input  flit_payload_t [NUM_PORTS-1:0]        in_flit,
    input  logic [NUM_PORTS-1:0]                 in_vc,
    input  logic [NUM_PORTS-1:0]                 data_ready_in,
    input  logic [NUM_PORTS-1:0][NUM_VCS-1:0]    buffer_available,
    input  flit_payload_t [NUM_PORTS-1:0]        out_flit,
    input  logic [NUM_PORTS-1:0]                 out_vc,
    input  logic [NUM_PORTS-1:0]                 data_ready_out,
    output int                                   err_cnt,
    output int                                   order_err,
    output int                                   outstanding
);
    port_id_t          shadow [TOTAL_NODES];
    logic [FLIT_W-1:0] exp_q [NUM_PORTS][NUM_VCS][NUM_PORTS][$];
    // Departures per output VC while downstream holds its credits
    int                held_cnt [NUM_PORTS][NUM_VCS];

    always @(posedge clk) begin
        logic          found;
        logic          any;
        logic [FLIT_W-1:0] head;
        int            v;
        port_id_t      dst_port;
        flit_payload_t f;
        // Outputs idle and buffers empty until stimulus starts
        if (!rst_n || test_name == "reset") begin
            if (data_ready_out != '0) begin
                $display("[ERROR] %0s expected %h actual %h", test_name, 4'h0, data_ready_out);
                err_cnt++;
            end
            if (buffer_available != '1) begin
                $display("[ERROR] %0s expected %h actual %h", test_name, 8'hff, buffer_available);
                err_cnt++;
            end
        end
        if (!rst_n) begin
            // Same defaults as the route table
            for (int n = 0; n < TOTAL_NODES; n++) begin
                shadow[n] = (n == int'(NODE)) ? '0 : port_id_t'(n % NUM_PORTS);
            end
            outstanding = 0;
            foreach (held_cnt[o, c]) begin
                held_cnt[o][c] = 0;
            end
        end else begin
            if (!hold) begin
                foreach (held_cnt[o, c]) begin
                    held_cnt[o][c] = 0;
                end
            end
            for (int o = 0; o < NUM_PORTS; o++) begin
                if (data_ready_out[o]) begin
                    v = out_vc[o];
                    if (hold) begin
                        held_cnt[o][v]++;
                        if (held_cnt[o][v] == BUFFER_SIZE + 1) begin
                            $display("[ERROR] %0s expected at most %0d actual %0d", test_name,
                                     BUFFER_SIZE, held_cnt[o][v]);
                            err_cnt++;
                        end
                    end
                    found = 1'b0;
                    any = 1'b0;
                    // Only the head of each input queue may leave next
                    for (int p = 0; p < NUM_PORTS; p++) begin
                        if (!found && exp_q[p][v][o].size() > 0) begin
                            any = 1'b1;
                            head = exp_q[p][v][o][0];
                            if (head == out_flit[o]) begin
                                void'(exp_q[p][v][o].pop_front());
                                found = 1'b1;
                                outstanding--;
                            end
                        end
                    end
                    if (!found && any) begin
                        $display("[ERROR] %0s expected %h actual %h", test_name, head, out_flit[o]);
                        err_cnt++;
                        order_err++;
                    end else if (!found) begin
                        $display("Unexpected flit %h on output %0d vc %0d during %0s",
                                 out_flit[o], o, v, test_name);
                        err_cnt++;
                    end
                end
            end
            for (int p = 0; p < NUM_PORTS; p++) begin
                if (data_ready_in[p]) begin
                    f = in_flit[p];
                    if (f.data.format == FMT_SWITCH_CFG && f.data.dest == NODE) begin
                        shadow[f.cfg.table_index] = f.cfg.route_port;
                    end else begin
                        dst_port = (f.data.dest == NODE) ? '0 : shadow[f.data.dest];
                        exp_q[p][in_vc[p]][dst_port].push_back(f);
                        outstanding++;
                    end
                end
            end
        end
    end

endmodule

// ==== test/switch_tb.sv ====
`timescale 1ns/10ps

module switch_tb;
    import chiplet_types_pkg::*;

    localparam int NUM_PORTS = 4;
    localparam int BUFFER_SIZE = 4;
    localparam int TOTAL_NODES = 32;
    localparam node_id_t NODE = 5'd3;

    logic                               clk;
    logic                               rst_n;
    flit_payload_t [NUM_PORTS-1:0]      in_flit;
    logic [NUM_PORTS-1:0]               in_vc;
    logic [NUM_PORTS-1:0]               data_ready_in;
    logic [NUM_PORTS-1:0][NUM_VCS-1:0]  buffer_available;
    flit_payload_t [NUM_PORTS-1:0]      out_flit;
    logic [NUM_PORTS-1:0]               out_vc;
    logic [NUM_PORTS-1:0]               data_ready_out;
    logic [NUM_PORTS-1:0][NUM_VCS-1:0]  credit_granted;
    logic [8*12-1:0]                    test_name;
    int                                 err_cnt;
    int                                 order_err;
    int                                 outstanding;
    logic [31:0]                        seed;
    logic [31:0]                        credit_seed;
    logic                               hold;
    int                                 pending [NUM_PORTS][NUM_VCS];
    int                                 seq;
    int                                 ntests;
    int                                 npass;
    int                                 base;

    switch #(
        .NUM_PORTS(NUM_PORTS), .BUFFER_SIZE(BUFFER_SIZE),
        .TOTAL_NODES(TOTAL_NODES), .NODE(NODE)
    ) dut0 (
        .clk(clk), .rst_n(rst_n), .in_flit(in_flit), .in_vc(in_vc),
        .data_ready_in(data_ready_in), .buffer_available(buffer_available),
        .out_flit(out_flit), .out_vc(out_vc), .data_ready_out(data_ready_out),
        .credit_granted(credit_granted)
    );

    switch_checker #(
        .NUM_PORTS(NUM_PORTS), .BUFFER_SIZE(BUFFER_SIZE),
        .TOTAL_NODES(TOTAL_NODES), .NODE(NODE)
    ) chk0 (
        .clk(clk), .rst_n(rst_n), .test_name(test_name), .hold(hold), .in_flit(in_flit),
        .in_vc(in_vc), .data_ready_in(data_ready_in),
        .buffer_available(buffer_available), .out_flit(out_flit), .out_vc(out_vc),
        .data_ready_out(data_ready_out), .err_cnt(err_cnt), .order_err(order_err),
        .outstanding(outstanding)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // Downstream returns each credit after a random delay unless held
    always @(posedge clk) begin
        for (int o = 0; o < NUM_PORTS; o++) begin
            for (int v = 0; v < NUM_VCS; v++) begin
                credit_seed = lcg_next(credit_seed);
                if (rst_n && !hold && pending[o][v] > 0 && credit_seed[20]) begin
                    credit_granted[o][v] <= 1'b1;
                    pending[o][v]--;
                end else begin
                    credit_granted[o][v] <= 1'b0;
                end
                if (rst_n && data_ready_out[o] && out_vc[o] == 1'(v)) begin
                    pending[o][v]++;
                end
            end
        end
    end

    // True once every departed flit has had its credit returned
    function automatic logic credits_returned();
        for (int o = 0; o < NUM_PORTS; o++) begin
            for (int v = 0; v < NUM_VCS; v++) begin
                if (pending[o][v] != 0) begin
                    return 1'b0;
                end
            end
        end
        return 1'b1;
    endfunction

    task automatic send_data(input int cycles);
        data_word_t w;
        logic       v;
        repeat (cycles) begin
            @(posedge clk);
            for (int p = 0; p < NUM_PORTS; p++) begin
                seed = lcg_next(seed);
                v = seed[17];
                // Last cycle's write is not yet in the level
                if (seed[23] && buffer_available[p][v]
                        && !(data_ready_in[p] && in_vc[p] == v)) begin
                    w.format = FMT_DATA;
                    w.dest = seed[30:26];
                    w.payload = {16'(seq), 2'(p), v, seed[11:8]};
                    seq++;
                    in_flit[p] <= w;
                    in_vc[p] <= v;
                    data_ready_in[p] <= 1'b1;
                end else begin
                    data_ready_in[p] <= 1'b0;
                end
            end
        end
        @(posedge clk);
        data_ready_in <= '0;
    endtask

    task automatic send_cfg(input int p, input node_id_t dest, input node_id_t idx,
                            input port_id_t route);
        cfg_word_t c;
        int        t;
        c = '{FMT_SWITCH_CFG, dest, idx, route, 16'h0};
        t = 0;
        @(posedge clk);
        while (!buffer_available[p][0]) begin
            t++;
            if (t > 500) begin
                $display("Timeout waiting for buffer space on port %0d", p);
                $display("Test failed");
                $finish;
            end
            @(posedge clk);
        end
        in_flit[p] <= c;
        in_vc[p] <= 1'b0;
        data_ready_in[p] <= 1'b1;
        @(posedge clk);
        data_ready_in[p] <= 1'b0;
    endtask

    task automatic wait_drain();
        int t;
        t = 0;
        while (outstanding != 0 || !credits_returned()) begin
            t++;
            if (t > 3000) begin
                $display("Timeout while draining, %0d flits still missing", outstanding);
                $display("Test failed");
                $finish;
            end
            @(posedge clk);
        end
    endtask

    task automatic finish_test(input logic [8*12-1:0] name, input logic ok);
        ntests++;
        if (ok) npass++;
        $display("%0s: %0s", name, ok ? "pass" : "FAIL");
    endtask

    initial begin
        seed = 32'h8a569e04;
        credit_seed = 32'h8a569e04 ^ 32'h5555aaaa;
        rst_n = 1'b0;
        in_flit = '0;
        in_vc = '0;
        data_ready_in = '0;
        credit_granted = '0;
        hold = 1'b0;
        seq = 0;
        ntests = 0;
        npass = 0;
        foreach (pending[o, v]) pending[o][v] = 0;
        test_name = "reset";
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        repeat (3) @(posedge clk);
        finish_test("reset", err_cnt == 0);

        test_name = "default";
        base = err_cnt;
        send_data(200);
        wait_drain();
        finish_test("default", err_cnt == base);

        // Distinct indices, since claims from different inputs may reorder
        test_name = "config";
        base = err_cnt;
        for (int i = 0; i < 4; i++) begin
            seed = lcg_next(seed);
            // Route differs from the default so each update shows
            send_cfg(i, NODE, node_id_t'(8 + i), port_id_t'(i + 1 + int'(seed[24])));
        end
        send_cfg(1, 5'd6, 5'd20, 2'd1);
        wait_drain();
        send_data(200);
        wait_drain();
        finish_test("config", err_cnt == base);

        test_name = "backpressure";
        base = err_cnt;
        hold <= 1'b1;
        send_data(80);
        hold <= 1'b0;
        wait_drain();
        finish_test("backpressure", err_cnt == base);

        finish_test("ordering", order_err == 0);

        test_name = "drain";
        base = err_cnt;
        send_data(150);
        wait_drain();
        repeat (50) @(posedge clk);
        finish_test("drain", err_cnt == base && outstanding == 0);

        $display("%0d of %0d tests passed, %0d errors", npass, ntests, err_cnt);
        if (npass == ntests && err_cnt == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== switch.f ====
rtl/chiplet_types_pkg.sv
rtl/vc_input_buffers.sv
rtl/route_compute.sv
rtl/switch_reg_bank.sv
rtl/switch_allocator.sv
rtl/crossbar.sv
rtl/switch.sv
test/switch_checker.sv
test/switch_tb.sv
